// File: all.f
+incdir+source
source/core_pkg.sv
source/stage_decode.sv
source/stage_execute.sv
source/stage_writeback.sv
source/int_pipe_top.sv
dv/int_pipe_sva.sv
dv/int_pipe_tb.sv

// File: dv/int_pipe_sva.sv
`timescale 1ns/10ps

module int_pipe_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                inst_valid,
    input logic                retire_valid,
    input logic                retire_wen,
    input core_pkg::reg_addr_t retire_rd,
    input core_pkg::count_t    clock_count
);

    import core_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // pipeline properties
    //////////////////////////////////////////////////////////////////////

    a_quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    // two register stages between issue and retirement.
    a_two_cycle_latency: assert property (
        @(posedge clk) disable iff (!rst_n) retire_valid == $past(inst_valid, 2))
        else $error("retire_valid does not follow inst_valid by two cycles");

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n) retire_wen |-> retire_rd != '0)
        else $error("register write reported for x0");

    a_clock_count_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> clock_count == $past(clock_count) + 1'b1)
        else $error("clock_count did not advance by one");

endmodule

bind int_pipe_top int_pipe_sva sva0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_rd    (retire_rd),
    .clock_count  (clock_count)
);

// File: dv/int_pipe_tb.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module int_pipe_tb;

    import core_pkg::*;

    localparam int NUM_INSTS    = 400;
    localparam int RESET_CYCLES = 5;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    pc_t       inst_pc;
    inst_t     inst;
    reg_addr_t dbg_addr;
    uint_x     dbg_data;
    logic      retire_valid;
    pc_t       retire_pc;
    logic      retire_wen;
    reg_addr_t retire_rd;
    uint_x     retire_wdata;
    count_t    inst_count;
    count_t    clock_count;

    uint_x     ref_regs [`NUM_REGS];
    pc_t       exp_pc[$];
    logic      exp_wen[$];
    reg_addr_t exp_rd[$];
    uint_x     exp_wdata[$];
    count_t    exp_cycle[$];
    count_t    cyc = '0;
    count_t    issued = '0;
    int        retired = 0;

    int_pipe_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input uint_x expected, input uint_x actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t expected,
                             input reg_addr_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
            end_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // returns the write enable and executes the word on ref_regs' current values.
    function automatic logic ref_execute(input inst_t w, output uint_x res);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       alt;
        logic       ok;
        uint_x      a;
        uint_x      b;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        alt = (f7 == `F7_ALT);
        a   = ref_regs[w[19:15]];
        b   = (opc == `OP_REG) ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        res = '0;
        ok  = 1'b1;
        if (opc == `OP_LUI) begin
            res = {w[31:12], 12'h000};
        end else if (opc == `OP_IMM || opc == `OP_REG) begin
            if (opc == `OP_REG)
                ok = (f7 == `F7_BASE) || (alt && (f3 == `F3_ADD || f3 == `F3_SR));
            else if (f3 == `F3_SLL)
                ok = (f7 == `F7_BASE);
            else if (f3 == `F3_SR)
                ok = (f7 == `F7_BASE) || alt;
            case (f3)
                `F3_ADD:  res = (opc == `OP_REG && alt) ? a - b : a + b;
                `F3_SLL:  res = a << b[4:0];
                `F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                `F3_XOR:  res = a ^ b;
                `F3_SR:   res = alt ? uint_x'($signed(a) >>> b[4:0]) : a >> b[4:0];
                `F3_OR:   res = a | b;
                `F3_AND:  res = a & b;
            endcase
        end else begin
            ok = 1'b0;  // loads, stores and branches are not executed.
        end
        return ok && (w[11:7] != 5'd0);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // mostly x0 to x5 so that back-to-back dependencies are frequent.
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(0, 7) != 0)
            return reg_addr_t'($urandom_range(0, 5));
        return reg_addr_t'($urandom_range(0, 31));
    endfunction

    function automatic inst_t make_inst();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom());
        kind = $urandom_range(0, 19);
        if (kind < 8) begin
            if (f3 == `F3_SLL)
                imm[11:5] = ($urandom_range(0, 7) == 0) ? 7'b0000001 : `F7_BASE;
            else if (f3 == `F3_SR)
                imm[11:5] = ($urandom_range(0, 1) != 0) ? `F7_ALT : `F7_BASE;
            return {imm, rs1, f3, rd, `OP_IMM};
        end
        if (kind < 16) begin
            f7 = ($urandom_range(0, 1) != 0) ? `F7_ALT : `F7_BASE;
            if ($urandom_range(0, 15) == 0)
                f7 = 7'b0000001;  // multiply extension, not supported.
            return {f7, rs2, rs1, f3, rd, `OP_REG};
        end
        if (kind < 18)
            return {20'($urandom()), rd, `OP_LUI};
        return {25'($urandom()), ($urandom_range(0, 1) != 0) ? 7'b1100011 : 7'b0000011};
    endfunction

    task automatic issue_inst(input inst_t w);
        uint_x res;
        logic  wen;
        wen = ref_execute(w, res);
        inst       = w;
        inst_valid = 1'b1;
        exp_pc.push_back(inst_pc);
        exp_wen.push_back(wen);
        exp_rd.push_back(w[11:7]);
        exp_wdata.push_back(res);
        exp_cycle.push_back(cyc);
        if (wen)
            ref_regs[w[11:7]] = res;
        issued = issued + 1'b1;
    endtask

    initial begin : stimulus
        int idle;
        int waited;
        void'($urandom(32'hf804_f3ea));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_pc    = 32'h0000_1000;
        inst       = '0;
        dbg_addr   = '0;
        for (int r = 0; r < `NUM_REGS; r++) ref_regs[r] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_INSTS; n++) begin
            @(negedge clk);
            if (n > 0) inst_pc = inst_pc + 32'd4;
            idle = 0;
            while (idle < 3 && $urandom_range(0, 3) == 0) begin
                inst_valid = 1'b0;  // idle cycle between instructions.
                idle++;
                @(negedge clk);
            end
            issue_inst(make_inst());
        end
        @(negedge clk);
        inst_valid = 1'b0;
        waited = 0;
        while (exp_pc.size() != 0) begin
            if (waited == 50) begin
                $display("pipeline did not drain within 50 cycles after the last issue");
                end_with_failure();
            end
            @(negedge clk);
            waited++;
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            @(negedge clk);
            dbg_addr = reg_addr_t'(r);
            @(posedge clk);
            check_word($sformatf("final x%0d", r), ref_regs[r], dbg_data);
        end
        @(negedge clk);
        check_count("inst_count", issued, inst_count);
        // every edge after the reset edges advances the cycle counter.
        check_count("clock_count", cyc - RESET_CYCLES, clock_count);
        $display("TEST RESULT: PASS");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // retirement compare
    //////////////////////////////////////////////////////////////////////

    initial begin : compare
        int    waited;
        string tag;
        forever begin
            @(negedge clk);
            if (exp_pc.size() != 0) begin
                waited = 0;
                while (!retire_valid) begin
                    if (waited == 10) begin
                        $display("no retirement within 10 cycles of a pending instruction");
                        end_with_failure();
                    end
                    @(negedge clk);
                    waited++;
                end
                tag = $sformatf("retire #%0d", retired);
                check_pc({tag, " pc"}, exp_pc[0], retire_pc);
                check_count({tag, " cycle"}, exp_cycle[0] + 2, cyc);
                check_flag({tag, " wen"}, exp_wen[0], retire_wen);
                check_reg({tag, " rd"}, exp_rd[0], retire_rd);
                if (exp_wen[0]) begin
                    check_word({tag, " wdata"}, exp_wdata[0], retire_wdata);
                end
                void'(exp_pc.pop_front());
                void'(exp_wen.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_wdata.pop_front());
                void'(exp_cycle.pop_front());
                retired++;
            end else if (retire_valid === 1'b1) begin
                $display("retirement seen with no instruction outstanding");
                end_with_failure();
            end
        end
    end

endmodule

// File: source/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

`define XLEN      32
`define ILEN      32
`define REG_AW    5
`define NUM_REGS  32
`define COUNT_W   64

//////////////////////////////////////////////////////////////////////
// major opcodes
//////////////////////////////////////////////////////////////////////

`define OP_IMM    7'b0010011  // register-immediate arithmetic.
`define OP_REG    7'b0110011  // register-register arithmetic.
`define OP_LUI    7'b0110111

//////////////////////////////////////////////////////////////////////
// funct3 and funct7 fields
//////////////////////////////////////////////////////////////////////

`define F3_ADD    3'b000
`define F3_SLL    3'b001
`define F3_SLT    3'b010
`define F3_SLTU   3'b011
`define F3_XOR    3'b100
`define F3_SR     3'b101  // srl and sra share this code.
`define F3_OR     3'b110
`define F3_AND    3'b111

`define F7_BASE   7'b0000000
`define F7_ALT    7'b0100000  // selects sub and sra.

//////////////////////////////////////////////////////////////////////
// ALU operation codes
//////////////////////////////////////////////////////////////////////

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_SLL   4'd2
`define ALU_SLT   4'd3
`define ALU_SLTU  4'd4
`define ALU_XOR   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_OR    4'd8
`define ALU_AND   4'd9
`define ALU_PASSB 4'd10  // result is op_b, used by lui.

`endif

// File: source/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    //////////////////////////////////////////////////////////////////
    // datapath words
    //////////////////////////////////////////////////////////////////

    typedef logic [`XLEN-1:0]    uint_x;      // operands, results and data values.
    typedef logic [`ILEN-1:0]    inst_t;
    typedef logic [`XLEN-1:0]    pc_t;

    //////////////////////////////////////////////////////////////////
    // control fields
    //////////////////////////////////////////////////////////////////

    typedef logic [`REG_AW-1:0]  reg_addr_t;  // one of the architectural registers.
    typedef logic [3:0]          alu_op_t;    // holds one of the ALU_ codes.

    // wide enough that neither counter wraps in any realistic run.
    typedef logic [`COUNT_W-1:0] count_t;

endpackage

// File: source/int_pipe_top.sv
`timescale 1ns/10ps

module int_pipe_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  core_pkg::pc_t       inst_pc,
    input  core_pkg::inst_t     inst,
    input  core_pkg::reg_addr_t dbg_addr,
    output core_pkg::uint_x     dbg_data,
    output logic                retire_valid,
    output core_pkg::pc_t       retire_pc,
    output logic                retire_wen,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::uint_x     retire_wdata,
    output core_pkg::count_t    inst_count,
    output core_pkg::count_t    clock_count
);

    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    uint_x     rs1_data;
    uint_x     rs2_data;

    logic      id_valid;
    pc_t       id_pc;
    alu_op_t   id_alu_op;
    uint_x     id_op_a;
    uint_x     id_op_b;
    logic      id_rf_wen;
    reg_addr_t id_rd;

    uint_x     ex_result;
    logic      wb_valid;
    pc_t       wb_pc;
    logic      wb_rf_wen;
    reg_addr_t wb_rd;
    uint_x     wb_wdata;

    // the decode register doubles as the execute stage's forwarding tag.
    stage_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst       (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .ex_valid   (id_valid),
        .ex_rf_wen  (id_rf_wen),
        .ex_rd      (id_rd),
        .ex_result  (ex_result),
        .wb_valid   (wb_valid),
        .wb_rf_wen  (wb_rf_wen),
        .wb_rd      (wb_rd),
        .wb_wdata   (wb_wdata),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_alu_op  (id_alu_op),
        .id_op_a    (id_op_a),
        .id_op_b    (id_op_b),
        .id_rf_wen  (id_rf_wen),
        .id_rd      (id_rd)
    );

    stage_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .id_pc      (id_pc),
        .id_alu_op  (id_alu_op),
        .id_op_a    (id_op_a),
        .id_op_b    (id_op_b),
        .id_rf_wen  (id_rf_wen),
        .id_rd      (id_rd),
        .ex_result  (ex_result),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_rf_wen  (wb_rf_wen),
        .wb_rd      (wb_rd),
        .wb_wdata   (wb_wdata)
    );

    stage_writeback u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (wb_valid),
        .pc           (wb_pc),
        .rf_wen       (wb_rf_wen),
        .rd           (wb_rd),
        .wdata        (wb_wdata),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .dbg_addr     (dbg_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .dbg_data     (dbg_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .inst_count   (inst_count),
        .clock_count  (clock_count)
    );

endmodule

// File: source/stage_decode.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module stage_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  core_pkg::pc_t       inst_pc,
    input  core_pkg::inst_t     inst,
    input  core_pkg::uint_x     rs1_data,
    input  core_pkg::uint_x     rs2_data,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  logic                ex_valid,
    input  logic                ex_rf_wen,
    input  core_pkg::reg_addr_t ex_rd,
    input  core_pkg::uint_x     ex_result,
    input  logic                wb_valid,
    input  logic                wb_rf_wen,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::uint_x     wb_wdata,
    output logic                id_valid,
    output core_pkg::pc_t       id_pc,
    output core_pkg::alu_op_t   id_alu_op,
    output core_pkg::uint_x     id_op_a,
    output core_pkg::uint_x     id_op_b,
    output logic                id_rf_wen,
    output core_pkg::reg_addr_t id_rd
);

    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    uint_x      imm_i;
    uint_x      imm_u;
    uint_x      shamt;
    uint_x      imm;
    alu_op_t    alu_op;
    logic       supported;
    logic       use_rs1;
    logic       use_rs2;
    uint_x      op_a;
    uint_x      op_b;

    //////////////////////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////////////////////

    assign opcode   = inst[6:0];
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, inst[24:20]};

    always_comb begin
        alu_op    = `ALU_ADD;
        imm       = imm_i;
        supported = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (opcode)
            `OP_IMM: begin
                use_rs1   = 1'b1;
                supported = 1'b1;
                case (funct3)
                    `F3_ADD:  alu_op = `ALU_ADD;
                    `F3_SLT:  alu_op = `ALU_SLT;
                    `F3_SLTU: alu_op = `ALU_SLTU;
                    `F3_XOR:  alu_op = `ALU_XOR;
                    `F3_OR:   alu_op = `ALU_OR;
                    `F3_AND:  alu_op = `ALU_AND;
                    `F3_SLL: begin
                        alu_op    = `ALU_SLL;
                        imm       = shamt;
                        supported = (funct7 == `F7_BASE);
                    end
                    `F3_SR: begin
                        alu_op    = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
                        imm       = shamt;
                        supported = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                    end
                endcase
            end
            `OP_REG: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                supported = (funct7 == `F7_BASE) ||
                            (funct7 == `F7_ALT && (funct3 == `F3_ADD || funct3 == `F3_SR));
                case (funct3)
                    `F3_ADD:  alu_op = (funct7 == `F7_ALT) ? `ALU_SUB : `ALU_ADD;
                    `F3_SLL:  alu_op = `ALU_SLL;
                    `F3_SLT:  alu_op = `ALU_SLT;
                    `F3_SLTU: alu_op = `ALU_SLTU;
                    `F3_XOR:  alu_op = `ALU_XOR;
                    `F3_SR:   alu_op = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
                    `F3_OR:   alu_op = `ALU_OR;
                    `F3_AND:  alu_op = `ALU_AND;
                endcase
            end
            `OP_LUI: begin
                alu_op    = `ALU_PASSB;
                imm       = imm_u;
                supported = 1'b1;
            end
            default: ;  // unsupported encodings retire without a write.
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // operand forwarding
    //////////////////////////////////////////////////////////////////

    // the younger result in execute wins over the one in writeback.
    function automatic uint_x forward(input reg_addr_t addr, input uint_x rf_data);
        if (ex_valid && ex_rf_wen && ex_rd == addr)
            return ex_result;
        if (wb_valid && wb_rf_wen && wb_rd == addr)
            return wb_wdata;
        return rf_data;
    endfunction

    always_comb begin
        op_a = use_rs1 ? forward(rs1_addr, rs1_data) : '0;
        op_b = use_rs2 ? forward(rs2_addr, rs2_data) : imm;
    end

    //////////////////////////////////////////////////////////////////
    // decode/execute register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            id_rf_wen <= 1'b0;
        end else begin
            id_valid  <= inst_valid;
            id_rf_wen <= inst_valid && supported && (rd != '0);  // keeps x0 at zero.
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            id_pc     <= inst_pc;
            id_alu_op <= alu_op;
            id_op_a   <= op_a;
            id_op_b   <= op_b;
            id_rd     <= rd;
        end
    end

endmodule

// File: source/stage_execute.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module stage_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                id_valid,
    input  core_pkg::pc_t       id_pc,
    input  core_pkg::alu_op_t   id_alu_op,
    input  core_pkg::uint_x     id_op_a,
    input  core_pkg::uint_x     id_op_b,
    input  logic                id_rf_wen,
    input  core_pkg::reg_addr_t id_rd,
    output core_pkg::uint_x     ex_result,
    output logic                wb_valid,
    output core_pkg::pc_t       wb_pc,
    output logic                wb_rf_wen,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::uint_x     wb_wdata
);

    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    //////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////

    assign shamt       = id_op_b[4:0];  // only the low five bits count for rv32.
    assign lt_signed   = $signed(id_op_a) < $signed(id_op_b);
    assign lt_unsigned = id_op_a < id_op_b;

    always_comb begin
        case (id_alu_op)
            `ALU_ADD:   ex_result = id_op_a + id_op_b;
            `ALU_SUB:   ex_result = id_op_a - id_op_b;
            `ALU_SLL:   ex_result = id_op_a << shamt;
            `ALU_SLT:   ex_result = {{(`XLEN-1){1'b0}}, lt_signed};
            `ALU_SLTU:  ex_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            `ALU_XOR:   ex_result = id_op_a ^ id_op_b;
            `ALU_SRL:   ex_result = id_op_a >> shamt;
            `ALU_SRA:   ex_result = uint_x'($signed(id_op_a) >>> shamt);
            `ALU_OR:    ex_result = id_op_a | id_op_b;
            `ALU_AND:   ex_result = id_op_a & id_op_b;
            `ALU_PASSB: ex_result = id_op_b;
            default:    ex_result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // execute/writeback register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            wb_rf_wen <= 1'b0;
        end else begin
            wb_valid  <= id_valid;
            wb_rf_wen <= id_valid && id_rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            wb_pc    <= id_pc;
            wb_rd    <= id_rd;
            wb_wdata <= ex_result;
        end
    end

endmodule

// File: source/stage_writeback.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module stage_writeback (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  core_pkg::pc_t       pc,
    input  logic                rf_wen,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::uint_x     wdata,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::reg_addr_t dbg_addr,
    output core_pkg::uint_x     rs1_data,
    output core_pkg::uint_x     rs2_data,
    output core_pkg::uint_x     dbg_data,
    output logic                retire_valid,
    output core_pkg::pc_t       retire_pc,
    output logic                retire_wen,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::uint_x     retire_wdata,
    output core_pkg::count_t    inst_count,
    output core_pkg::count_t    clock_count
);

    import core_pkg::*;

    uint_x regs [`NUM_REGS];

    //////////////////////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////////////////////

    // decode never sets rf_wen for x0, so entry zero stays at its reset value.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (valid && rf_wen) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

    //////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clock_count <= '0;
            inst_count  <= '0;
        end else begin
            clock_count <= clock_count + 1'b1;
            if (valid) begin
                inst_count <= inst_count + 1'b1;  // unsupported words count too.
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // retirement report
    //////////////////////////////////////////////////////////////////

    assign retire_valid = valid;
    assign retire_pc    = pc;
    assign retire_wen   = valid && rf_wen;
    assign retire_rd    = rd;
    assign retire_wdata = wdata;

endmodule
